//--- nib_core.f
src/nib_pkg.sv
src/nib_state.sv
src/nib_decode.sv
src/nib_immdec.sv
src/nib_alu.sv
src/nib_ctrl.sv
src/nib_rf_if.sv
src/nib_core_top.sv
testbench/tb_nib_core.sv

//--- run.sh
#!/bin/sh
# Build and run the nibble-serial core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_nib_core -f nib_core.f -o sim_nib_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_nib_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- src/nib_alu.sv
`timescale 1ns/100ps

module nib_alu #(
   parameter int W = 4
) (
   input  logic             clk,
   input  logic             i_cnt_en,
   input  logic             i_cnt0,
   input  nib_pkg::alu_op_e i_alu_op,
   input  logic [W-1:0]     i_rs1,
   input  logic [W-1:0]     i_op_b,
   output logic [W-1:0]     o_rd
);

   logic         sub;
   logic         cin;
   logic         carry_q;
   logic [W-1:0] b_eff;
   logic [W:0]   sum;

   assign sub   = (i_alu_op == nib_pkg::ALU_SUB);
   assign b_eff = sub ? ~i_op_b : i_op_b;

   // Two's complement needs the +1 on the first nibble
   assign cin = i_cnt0 ? sub : carry_q;
   assign sum = {1'b0, i_rs1} + {1'b0, b_eff} + {{W{1'b0}}, cin};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= sum[W];
      end
   end

   always_comb begin
      case (i_alu_op)
         nib_pkg::ALU_AND: o_rd = i_rs1 & i_op_b;
         nib_pkg::ALU_OR:  o_rd = i_rs1 | i_op_b;
         nib_pkg::ALU_XOR: o_rd = i_rs1 ^ i_op_b;
         default:          o_rd = sum[W-1:0];
      endcase
   end

endmodule

//--- src/nib_core_top.sv
`timescale 1ns/100ps

module nib_core_top #(
   parameter int             W        = 4,
   parameter nib_pkg::word_t RESET_PC = '0
) (
   input  logic               clk,
   input  logic               i_reset,
   input  nib_pkg::word_t     i_ibus_rdt,
   input  logic               i_ibus_ack,
   input  logic               i_rf_ready,
   input  logic [W-1:0]       i_rdata0,
   input  logic [W-1:0]       i_rdata1,
   output nib_pkg::word_t     o_ibus_adr,
   output logic               o_ibus_cyc,
   output logic               o_rf_rreq,
   output nib_pkg::reg_addr_t o_rreg0,
   output nib_pkg::reg_addr_t o_rreg1,
   output nib_pkg::reg_addr_t o_wreg0,
   output logic               o_wen0,
   output logic [W-1:0]       o_wdata0
);

   logic               cnt_en;
   logic               cnt0;
   logic               cnt_done;
   nib_pkg::alu_op_e   alu_op;
   logic               op_b_imm;
   nib_pkg::rd_sel_e   rd_sel;
   nib_pkg::imm_fmt_e  imm_fmt;
   logic               rd_write;
   logic               pc_rel_jump;
   logic               auipc;
   nib_pkg::reg_addr_t rs1_addr;
   nib_pkg::reg_addr_t rs2_addr;
   nib_pkg::reg_addr_t rd_addr;
   logic [W-1:0]       imm;
   logic [W-1:0]       op_b;
   logic [W-1:0]       alu_rd;
   logic [W-1:0]       pc_rd;

   // Second operand is the immediate for OP-IMM
   assign op_b = op_b_imm ? imm : i_rdata1;

   nib_state #(.W(W)) state_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   nib_decode decode_i (
      .clk           (clk),
      .i_ibus_ack    (i_ibus_ack),
      .i_instr       (i_ibus_rdt),
      .o_alu_op      (alu_op),
      .o_op_b_imm    (op_b_imm),
      .o_rd_sel      (rd_sel),
      .o_imm_fmt     (imm_fmt),
      .o_rd_write    (rd_write),
      .o_pc_rel_jump (pc_rel_jump),
      .o_auipc       (auipc)
   );

   nib_immdec #(.W(W)) immdec_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .i_imm_fmt  (imm_fmt),
      .i_cnt_en   (cnt_en),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_imm      (imm)
   );

   nib_alu #(.W(W)) alu_i (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_alu_op (alu_op),
      .i_rs1    (i_rdata0),
      .i_op_b   (op_b),
      .o_rd     (alu_rd)
   );

   nib_ctrl #(.W(W), .RESET_PC(RESET_PC)) ctrl_i (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_cnt_en      (cnt_en),
      .i_cnt0        (cnt0),
      .i_cnt_done    (cnt_done),
      .i_imm         (imm),
      .i_pc_rel_jump (pc_rel_jump),
      .i_auipc       (auipc),
      .o_ibus_adr    (o_ibus_adr),
      .o_rd          (pc_rd)
   );

   nib_rf_if #(.W(W)) rf_if_i (
      .i_cnt_en   (cnt_en),
      .i_rd_write (rd_write),
      .i_rd_sel   (rd_sel),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_alu_rd   (alu_rd),
      .i_imm      (imm),
      .i_pc_rd    (pc_rd),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

endmodule

//--- src/nib_ctrl.sv
`timescale 1ns/100ps

module nib_ctrl #(
   parameter int             W        = 4,
   parameter nib_pkg::word_t RESET_PC = '0
) (
   input  logic           clk,
   input  logic           i_reset,
   input  logic           i_cnt_en,
   input  logic           i_cnt0,
   input  logic           i_cnt_done,
   input  logic [W-1:0]   i_imm,
   input  logic           i_pc_rel_jump,
   input  logic           i_auipc,
   output nib_pkg::word_t o_ibus_adr,
   output logic [W-1:0]   o_rd
);

   localparam int             KW   = (W > 4) ? W : 4;
   localparam logic [KW-1:0]  FOUR = KW'(4);
   localparam int             XL   = nib_pkg::XLEN;

   nib_pkg::word_t pc_q;
   nib_pkg::word_t nxt_q;
   logic [KW-1:0]  four_q;
   logic [W-1:0]   add4_b;
   logic [W-1:0]   new_nib;
   logic [W:0]     sum4;
   logic [W:0]     sumi;
   logic           c4_q;
   logic           ci_q;

   // The constant 4 may fall in a later nibble for narrow W
   assign add4_b = i_cnt0 ? FOUR[W-1:0] : four_q[W-1:0];

   assign sum4 = {1'b0, pc_q[W-1:0]} + {1'b0, add4_b}
               + {{W{1'b0}}, (i_cnt0 ? 1'b0 : c4_q)};
   assign sumi = {1'b0, pc_q[W-1:0]} + {1'b0, i_imm}
               + {{W{1'b0}}, (i_cnt0 ? 1'b0 : ci_q)};

   assign new_nib = i_pc_rel_jump ? sumi[W-1:0] : sum4[W-1:0];
   assign o_rd    = i_auipc ? sumi[W-1:0] : sum4[W-1:0];

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         c4_q   <= sum4[W];
         ci_q   <= sumi[W];
         four_q <= (i_cnt0 ? FOUR : four_q) >> W;
         nxt_q  <= {new_nib, nxt_q[XL-1:W]};
      end
   end

   // PC rotates while executing, then takes the collected next PC
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q <= RESET_PC;
      end else if (i_cnt_done) begin
         pc_q <= {new_nib, nxt_q[XL-1:W]};
      end else if (i_cnt_en) begin
         pc_q <= {pc_q[W-1:0], pc_q[XL-1:W]};
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

//--- src/nib_decode.sv
`timescale 1ns/100ps

module nib_decode (
   input  logic              clk,
   input  logic              i_ibus_ack,
   input  nib_pkg::word_t    i_instr,
   output nib_pkg::alu_op_e  o_alu_op,
   output logic              o_op_b_imm,
   output nib_pkg::rd_sel_e  o_rd_sel,
   output nib_pkg::imm_fmt_e o_imm_fmt,
   output logic              o_rd_write,
   output logic              o_pc_rel_jump,
   output logic              o_auipc
);

   logic [6:0] opcode_q;
   logic [2:0] funct3_q;
   logic       funct7b5_q;
   logic       alu_f3_ok;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         opcode_q   <= i_instr[6:0];
         funct3_q   <= i_instr[14:12];
         funct7b5_q <= i_instr[30];
      end
   end

   always_comb begin
      o_alu_op      = nib_pkg::ALU_ADD;
      o_op_b_imm    = 1'b0;
      o_rd_sel      = nib_pkg::RD_ALU;
      o_imm_fmt     = nib_pkg::IMM_I;
      o_rd_write    = 1'b0;
      o_pc_rel_jump = 1'b0;
      o_auipc       = 1'b0;
      alu_f3_ok     = 1'b1;

      // Shifts and compares are not implemented
      case (funct3_q)
         3'b000: begin
            if (opcode_q == nib_pkg::OPC_OP && funct7b5_q) begin
               o_alu_op = nib_pkg::ALU_SUB;
            end
         end
         3'b100:  o_alu_op = nib_pkg::ALU_XOR;
         3'b110:  o_alu_op = nib_pkg::ALU_OR;
         3'b111:  o_alu_op = nib_pkg::ALU_AND;
         default: alu_f3_ok = 1'b0;
      endcase

      case (opcode_q)
         nib_pkg::OPC_OP: begin
            o_rd_write = alu_f3_ok;
         end
         nib_pkg::OPC_OP_IMM: begin
            o_op_b_imm = 1'b1;
            o_rd_write = alu_f3_ok;
         end
         nib_pkg::OPC_LUI: begin
            o_rd_sel   = nib_pkg::RD_IMM;
            o_imm_fmt  = nib_pkg::IMM_U;
            o_rd_write = 1'b1;
         end
         nib_pkg::OPC_AUIPC: begin
            o_rd_sel   = nib_pkg::RD_PC;
            o_imm_fmt  = nib_pkg::IMM_U;
            o_rd_write = 1'b1;
            o_auipc    = 1'b1;
         end
         nib_pkg::OPC_JAL: begin
            o_rd_sel      = nib_pkg::RD_PC;
            o_imm_fmt     = nib_pkg::IMM_J;
            o_rd_write    = 1'b1;
            o_pc_rel_jump = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- src/nib_immdec.sv
`timescale 1ns/100ps

module nib_immdec #(
   parameter int W = 4
) (
   input  logic                clk,
   input  logic                i_ibus_ack,
   input  nib_pkg::word_t      i_instr,
   input  nib_pkg::imm_fmt_e   i_imm_fmt,
   input  logic                i_cnt_en,
   output nib_pkg::reg_addr_t  o_rs1_addr,
   output nib_pkg::reg_addr_t  o_rs2_addr,
   output nib_pkg::reg_addr_t  o_rd_addr,
   output logic [W-1:0]        o_imm
);

   logic [31:7]    instr_q;
   nib_pkg::word_t imm_full;
   nib_pkg::word_t imm_q;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr_q <= i_instr[31:7];
      end
   end

   assign o_rd_addr  = instr_q[11:7];
   assign o_rs1_addr = instr_q[19:15];
   assign o_rs2_addr = instr_q[24:20];

   always_comb begin
      case (i_imm_fmt)
         nib_pkg::IMM_U: imm_full = {instr_q[31:12], 12'h000};
         nib_pkg::IMM_J: imm_full = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20],
                                     instr_q[30:21], 1'b0};
         default:        imm_full = {{21{instr_q[31]}}, instr_q[30:20]};
      endcase
   end

   // Reloads between instructions, rotates out LSB first while executing
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         imm_q <= {imm_q[W-1:0], imm_q[nib_pkg::XLEN-1:W]};
      end else begin
         imm_q <= imm_full;
      end
   end

   assign o_imm = imm_q[W-1:0];

endmodule

//--- src/nib_pkg.sv
package nib_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // Major opcodes kept by this core
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // Source of the rd write stream
   typedef enum logic [1:0] {
      RD_ALU = 2'd0,
      RD_IMM = 2'd1,
      RD_PC  = 2'd2
   } rd_sel_e;

   typedef enum logic [1:0] {
      IMM_I = 2'd0,
      IMM_U = 2'd1,
      IMM_J = 2'd2
   } imm_fmt_e;

endpackage

//--- src/nib_rf_if.sv
`timescale 1ns/100ps

module nib_rf_if #(
   parameter int W = 4
) (
   input  logic               i_cnt_en,
   input  logic               i_rd_write,
   input  nib_pkg::rd_sel_e   i_rd_sel,
   input  nib_pkg::reg_addr_t i_rs1_addr,
   input  nib_pkg::reg_addr_t i_rs2_addr,
   input  nib_pkg::reg_addr_t i_rd_addr,
   input  logic [W-1:0]       i_alu_rd,
   input  logic [W-1:0]       i_imm,
   input  logic [W-1:0]       i_pc_rd,
   output nib_pkg::reg_addr_t o_rreg0,
   output nib_pkg::reg_addr_t o_rreg1,
   output nib_pkg::reg_addr_t o_wreg0,
   output logic               o_wen0,
   output logic [W-1:0]       o_wdata0
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg0 = i_rd_addr;

   // x0 is never written
   assign o_wen0 = i_cnt_en & i_rd_write & (|i_rd_addr);

   always_comb begin
      case (i_rd_sel)
         nib_pkg::RD_IMM: o_wdata0 = i_imm;
         nib_pkg::RD_PC:  o_wdata0 = i_pc_rd;
         default:         o_wdata0 = i_alu_rd;
      endcase
   end

endmodule

//--- src/nib_state.sv
`timescale 1ns/100ps

module nib_state #(
   parameter int W = 4
) (
   input  logic clk,
   input  logic i_reset,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   localparam int NCYC = 32 / W;
   localparam int CW   = $clog2(NCYC);

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_RF_WAIT,
      PH_EXEC
   } phase_e;

   phase_e        phase_q;
   logic [CW-1:0] cnt_q;
   logic          cyc_q;
   logic          rreq_q;
   logic          fetch_done;

   assign fetch_done = cyc_q & i_ibus_ack;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase_q <= PH_FETCH;
         cyc_q   <= 1'b0;
         rreq_q  <= 1'b0;
         cnt_q   <= '0;
      end else begin
         rreq_q <= 1'b0;
         case (phase_q)
            PH_FETCH: begin
               // Raise cyc on entry, drop it on the ack
               cyc_q <= !fetch_done;
               if (fetch_done) begin
                  rreq_q  <= 1'b1;
                  phase_q <= PH_RF_WAIT;
               end
            end
            PH_RF_WAIT: begin
               if (i_rf_ready) begin
                  phase_q <= PH_EXEC;
               end
            end
            PH_EXEC: begin
               // Wraps back to zero on the last nibble
               cnt_q <= cnt_q + 1'b1;
               if (o_cnt_done) begin
                  phase_q <= PH_FETCH;
                  cyc_q   <= 1'b1;
               end
            end
            default: phase_q <= PH_FETCH;
         endcase
      end
   end

   assign o_ibus_cyc = cyc_q;
   assign o_rf_rreq  = rreq_q;
   assign o_cnt_en   = (phase_q == PH_EXEC);
   assign o_cnt0     = o_cnt_en & (cnt_q == '0);
   assign o_cnt_done = o_cnt_en & (cnt_q == CW'(NCYC - 1));

   // Fetch and execute never overlap
   assert property (@(posedge clk) disable iff (i_reset) !(o_cnt_en && o_ibus_cyc));

   // Bus may only ack an open request
   assert property (@(posedge clk) disable iff (i_reset) i_ibus_ack |-> o_ibus_cyc);

endmodule

//--- testbench/tb_nib_core.sv
`timescale 1ns/100ps

module tb_nib_core;

   localparam int W       = 4;
   localparam int NCYC    = 32 / W;
   localparam int NUM     = 21;
   localparam int TIMEOUT = 50;

   logic               clk;
   logic               i_reset;
   nib_pkg::word_t     i_ibus_rdt;
   logic               i_ibus_ack;
   logic               i_rf_ready;
   logic [W-1:0]       i_rdata0;
   logic [W-1:0]       i_rdata1;
   nib_pkg::word_t     o_ibus_adr;
   logic               o_ibus_cyc;
   logic               o_rf_rreq;
   nib_pkg::reg_addr_t o_rreg0;
   nib_pkg::reg_addr_t o_rreg1;
   nib_pkg::reg_addr_t o_wreg0;
   logic               o_wen0;
   logic [W-1:0]       o_wdata0;

   // Register file model and the instruction table with its write flags
   nib_pkg::word_t regs [32];
   nib_pkg::word_t instr_tab [NUM];
   logic           wr_tab [NUM];

   nib_core_top #(.W(W), .RESET_PC(32'h0000_0000)) dut_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input nib_pkg::word_t exp,
                             input nib_pkg::word_t act);
      if (act !== exp) begin
         stop_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_addr(input string name, input nib_pkg::reg_addr_t exp,
                             input nib_pkg::reg_addr_t act);
      if (act !== exp) begin
         stop_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_pc(input nib_pkg::word_t exp, input nib_pkg::word_t act);
      if (act !== exp) begin
         stop_run($sformatf("ERR o_ibus_adr expected %h actual %h", exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_fetch();
      int n;
      n = 0;
      while (o_ibus_cyc !== 1'b1) begin
         if (n == TIMEOUT) begin
            stop_run("Timed out waiting for the core to start an instruction fetch");
         end
         check_flag("o_wen0", 1'b0, o_wen0);
         step();
         n++;
      end
   endtask

   task automatic wait_rreq();
      int n;
      n = 0;
      while (o_rf_rreq !== 1'b1) begin
         if (n == TIMEOUT) begin
            stop_run("Timed out waiting for the register file read request");
         end
         step();
         n++;
      end
   endtask

   // Instruction encoders
   function automatic nib_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
      enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic nib_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
      enc_i = {imm, rs1, f3, rd, opc};
   endfunction

   function automatic nib_pkg::word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
      enc_j = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   // Reference rd value of RV32I for the kept instructions
   function automatic nib_pkg::word_t ref_result(input nib_pkg::word_t instr,
                                                 input nib_pkg::word_t pc,
                                                 input nib_pkg::word_t a,
                                                 input nib_pkg::word_t b);
      nib_pkg::word_t imm_i;
      nib_pkg::word_t imm_u;
      nib_pkg::word_t opb;
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_u = {instr[31:12], 12'h000};
      opb   = (instr[6:0] == 7'b0010011) ? imm_i : b;
      case (instr[6:0])
         7'b0110111: ref_result = imm_u;
         7'b0010111: ref_result = pc + imm_u;
         7'b1101111: ref_result = pc + 32'd4;
         default: begin
            case (instr[14:12])
               3'b100:  ref_result = a ^ opb;
               3'b110:  ref_result = a | opb;
               3'b111:  ref_result = a & opb;
               default: ref_result = (instr[6:0] == 7'b0110011 && instr[30]) ?
                                     a - opb : a + opb;
            endcase
         end
      endcase
   endfunction

   function automatic nib_pkg::word_t ref_next_pc(input nib_pkg::word_t instr,
                                                  input nib_pkg::word_t pc);
      nib_pkg::word_t imm_j;
      imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      ref_next_pc = (instr[6:0] == 7'b1101111) ? pc + imm_j : pc + 32'd4;
   endfunction

   task automatic load_table();
      instr_tab[0]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5);
      wr_tab[0]     = 1'b1;
      instr_tab[1]  = enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd6);
      wr_tab[1]     = 1'b1;
      instr_tab[2]  = enc_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd7);
      wr_tab[2]     = 1'b1;
      instr_tab[3]  = enc_r(7'h00, 5'd1, 5'd4, 3'b111, 5'd8);
      wr_tab[3]     = 1'b1;
      instr_tab[4]  = enc_r(7'h00, 5'd2, 5'd3, 3'b110, 5'd9);
      wr_tab[4]     = 1'b1;
      instr_tab[5]  = enc_r(7'h00, 5'd7, 5'd4, 3'b100, 5'd10);
      wr_tab[5]     = 1'b1;
      instr_tab[6]  = enc_i(12'hffb, 5'd2, 3'b000, 5'd11, 7'b0010011);
      wr_tab[6]     = 1'b1;
      instr_tab[7]  = enc_i(12'hfff, 5'd4, 3'b100, 5'd12, 7'b0010011);
      wr_tab[7]     = 1'b1;
      instr_tab[8]  = enc_i(12'h800, 5'd2, 3'b110, 5'd13, 7'b0010011);
      wr_tab[8]     = 1'b1;
      instr_tab[9]  = enc_i(12'hff0, 5'd4, 3'b111, 5'd14, 7'b0010011);
      wr_tab[9]     = 1'b1;
      instr_tab[10] = {20'habcde, 5'd15, 7'b0110111};
      wr_tab[10]    = 1'b1;
      instr_tab[11] = {20'h12345, 5'd16, 7'b0010111};
      wr_tab[11]    = 1'b1;
      instr_tab[12] = enc_j(21'h000010, 5'd17);
      wr_tab[12]    = 1'b1;
      // Backward jump
      instr_tab[13] = enc_j(21'h1ffff8, 5'd18);
      wr_tab[13]    = 1'b1;
      instr_tab[14] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0);
      wr_tab[14]    = 1'b0;
      instr_tab[15] = enc_i(12'h001, 5'd4, 3'b000, 5'd0, 7'b0010011);
      wr_tab[15]    = 1'b0;
      // Load, system and branch are not supported
      instr_tab[16] = enc_i(12'h000, 5'd1, 3'b010, 5'd20, 7'b0000011);
      wr_tab[16]    = 1'b0;
      instr_tab[17] = 32'h0000_0073;
      wr_tab[17]    = 1'b0;
      instr_tab[18] = 32'h0020_8463;
      wr_tab[18]    = 1'b0;
      instr_tab[19] = enc_r(7'h00, 5'd16, 5'd5, 3'b000, 5'd21);
      wr_tab[19]    = 1'b1;
      instr_tab[20] = enc_r(7'h20, 5'd21, 5'd21, 3'b000, 5'd22);
      wr_tab[20]    = 1'b1;
   endtask

   initial begin
      int             delay;
      nib_pkg::word_t pc;
      nib_pkg::word_t rs1_val;
      nib_pkg::word_t rs2_val;
      nib_pkg::word_t result;
      nib_pkg::word_t exp_rd;

      i_reset    = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = '0;
      i_rdata1   = '0;
      void'($urandom(32'h3c4a9030));

      regs[0] = 32'h0000_0000;
      regs[1] = 32'h0fff_ffff;
      regs[2] = 32'h0000_0001;
      regs[3] = 32'h8000_0000;
      regs[4] = 32'hdead_beef;
      for (int i = 5; i < 32; i++) begin
         regs[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
      end
      load_table();

      repeat (4) begin
         step();
         check_flag("o_ibus_cyc", 1'b0, o_ibus_cyc);
         check_flag("o_rf_rreq", 1'b0, o_rf_rreq);
         check_flag("o_wen0", 1'b0, o_wen0);
      end
      i_reset = 1'b0;
      pc = 32'h0000_0000;

      for (int idx = 0; idx < NUM; idx++) begin
         wait_fetch();
         check_pc(pc, o_ibus_adr);
         delay = int'($urandom % 4);
         repeat (delay) begin
            step();
            check_flag("o_ibus_cyc", 1'b1, o_ibus_cyc);
            check_pc(pc, o_ibus_adr);
         end
         i_ibus_ack = 1'b1;
         i_ibus_rdt = instr_tab[idx];
         step();
         i_ibus_ack = 1'b0;

         wait_rreq();
         check_addr("o_rreg0", instr_tab[idx][19:15], o_rreg0);
         check_addr("o_rreg1", instr_tab[idx][24:20], o_rreg1);
         rs1_val = regs[o_rreg0];
         rs2_val = regs[o_rreg1];
         delay = int'($urandom % 4);
         repeat (delay) begin
            step();
            check_flag("o_rf_rreq", 1'b0, o_rf_rreq);
         end
         i_rf_ready = 1'b1;
         step();
         i_rf_ready = 1'b0;

         // Execute phase, one nibble per cycle, LSB first
         for (int k = 0; k < NCYC; k++) begin
            i_rdata0 = rs1_val[k*W +: W];
            i_rdata1 = rs2_val[k*W +: W];
            @(negedge clk);
            check_flag("o_wen0", wr_tab[idx], o_wen0);
            if (wr_tab[idx]) begin
               check_addr("o_wreg0", instr_tab[idx][11:7], o_wreg0);
            end
            result[k*W +: W] = o_wdata0;
            step();
         end

         if (wr_tab[idx]) begin
            exp_rd = ref_result(instr_tab[idx], pc, rs1_val, rs2_val);
            check_word("o_wdata0", exp_rd, result);
            regs[instr_tab[idx][11:7]] = result;
         end
         pc = ref_next_pc(instr_tab[idx], pc);
      end

      wait_fetch();
      check_pc(pc, o_ibus_adr);
      $display("Testbench passed");
      $finish;
   end

endmodule
